// ==== list.f ====
src/isa_pkg.sv
src/fetch_pkg.sv
src/sync_fifo.sv
src/pre_decoder.sv
src/fetch_buffer.sv
src/fetch_queue_top.sv
bench/fetch_queue_assert.sv
bench/fetch_queue_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_queue_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/fetch_queue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue_tb;
    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int BUF_DEPTH  = 8;
    localparam int MAX_CYCLES = 2000;  // tests take about 400

    logic          clk;
    logic          rst_n_i;
    logic          fetch_valid_i;
    fetch_bundle_t fetch_bundle_i;
    logic          decode_ready_i;
    queue_entry_t  decode_entry_o;
    logic [31:0]   pc_add_o;
    logic          fetch_buf_empty_o;
    logic          fetch_buf_full_o;
    logic          ibar_refetch_valid_o;
    logic [31:0]   ibar_refetch_pc_o;

    queue_entry_t  model_q [$];  // reference queue contents
    logic          exp_refetch_valid;
    logic [31:0]   exp_refetch_pc;
    fetch_bundle_t quiet;
    int            n_checks;
    int            n_errors;
    int            cycles = 0;

    fetch_queue_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) fetch_queue_top_i (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .fetch_valid_i        (fetch_valid_i),
        .fetch_bundle_i       (fetch_bundle_i),
        .decode_ready_i       (decode_ready_i),
        .decode_entry_o       (decode_entry_o),
        .pc_add_o             (pc_add_o),
        .fetch_buf_empty_o    (fetch_buf_empty_o),
        .fetch_buf_full_o     (fetch_buf_full_o),
        .ibar_refetch_valid_o (ibar_refetch_valid_o),
        .ibar_refetch_pc_o    (ibar_refetch_pc_o)
    );

    bind fetch_queue_top fetch_queue_assert fetch_queue_assert_i (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .fetch_valid_i        (fetch_valid_i),
        .fetch_bundle_i       (fetch_bundle_i),
        .decode_ready_i       (decode_ready_i),
        .decode_entry_i       (decode_entry_o),
        .fetch_buf_empty_i    (fetch_buf_empty_o),
        .fetch_buf_full_i     (fetch_buf_full_o),
        .ibar_refetch_valid_i (ibar_refetch_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [1:0] ibar_slots(input fetch_bundle_t b);
        logic [1:0] f;
        f[0] = (b.inst0[31:15] == IBAR_OPCODE);
        f[1] = (b.inst1[31:15] == IBAR_OPCODE);
        return f;
    endfunction

    function automatic queue_entry_t make_entry(input fetch_bundle_t b);
        queue_entry_t e;
        e.bundle    = b;
        e.ibar_flag = ibar_slots(b);
        return e;
    endfunction

    function automatic queue_entry_t idle_entry();
        queue_entry_t e;
        e                = '0;
        e.bundle.inst0   = INST_NOP;
        e.bundle.inst1   = INST_NOP;
        e.bundle.pc      = PC_RESET;
        e.bundle.pc_next = PC_RESET + 32'd8;
        e.bundle.badv    = PC_RESET;
        return e;
    endfunction

    function automatic logic [31:0] ibar_word();
        logic [31:0] r;
        r = $urandom;
        return {IBAR_OPCODE, r[14:0]};  // random hint
    endfunction

    // ibar_slot 1 or 2 puts an ibar in inst0 or inst1
    function automatic fetch_bundle_t rand_bundle(input int ibar_slot);
        fetch_bundle_t b;
        logic [31:0]   r;
        b.inst0 = (ibar_slot == 1) ? ibar_word() : ($urandom | 32'h8000_0000);
        b.inst1 = (ibar_slot == 2) ? ibar_word() : ($urandom | 32'h8000_0000);
        r = $urandom;
        b.pc      = {r[31:3], 3'b000};
        b.pc_next = b.pc + 32'd8;
        b.badv    = $urandom;
        b.cookie  = $urandom;
        r = $urandom;
        b.exception      = r[6:0];
        b.excp_flag      = r[8:7];
        b.cacop_ready    = r[9];
        b.cacop_complete = r[10];
        return b;
    endfunction

    task automatic compare(input string what, input logic [255:0] got,
                           input logic [255:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // drive at the falling edge, check mid cycle and update the model at the rising edge
    task automatic drive_cycle(input logic valid, input logic ready, input fetch_bundle_t b);
        queue_entry_t in_e;
        queue_entry_t exp_e;
        logic         empty;
        logic         full;
        logic         bypass;
        logic         push;
        @(negedge clk);
        fetch_valid_i  = valid;
        decode_ready_i = ready;
        fetch_bundle_i = b;
        #1;
        in_e   = make_entry(b);
        empty  = (model_q.size() == 0);
        full   = (model_q.size() == BUF_DEPTH);
        bypass = empty && valid && ready;
        if (bypass) begin
            exp_e = in_e;
        end else if (!empty) begin
            exp_e = model_q[0];
        end else begin
            exp_e = idle_entry();
        end
        compare("decode_entry", 256'(decode_entry_o), 256'(exp_e));
        compare("pc_add", 256'(pc_add_o), 256'(exp_e.bundle.pc + 32'd4));
        compare("empty", 256'(fetch_buf_empty_o), 256'(empty));
        compare("full", 256'(fetch_buf_full_o), 256'(full));
        compare("refetch_valid", 256'(ibar_refetch_valid_o), 256'(exp_refetch_valid));
        if (exp_refetch_valid) begin
            compare("refetch_pc", 256'(ibar_refetch_pc_o), 256'(exp_refetch_pc));
        end
        @(posedge clk);
        push = valid && !full && !bypass;
        if (ready && !empty) begin
            void'(model_q.pop_front());
        end
        if (push) begin
            model_q.push_back(in_e);
        end
        if ((push || bypass) && (in_e.ibar_flag != 2'b00)) begin
            exp_refetch_valid = 1'b1;
            exp_refetch_pc    = b.pc + (in_e.ibar_flag[0] ? 32'd4 : 32'd8);
        end else begin
            exp_refetch_valid = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s finished with %0d errors", name, n_errors - errors_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = n_errors;
        drive_cycle(1'b0, 1'b0, quiet);
        drive_cycle(1'b0, 1'b1, quiet);  // pop on empty does nothing
        drive_cycle(1'b0, 1'b0, quiet);
        report_test("reset", e0);
    endtask

    task automatic test_order();
        int e0;
        e0 = n_errors;
        repeat (5) drive_cycle(1'b1, 1'b0, rand_bundle(0));
        repeat (6) drive_cycle(1'b0, 1'b1, quiet);
        report_test("order", e0);
    endtask

    task automatic test_bypass();
        int e0;
        e0 = n_errors;
        drive_cycle(1'b1, 1'b1, rand_bundle(0));
        drive_cycle(1'b0, 1'b0, quiet);
        drive_cycle(1'b1, 1'b1, rand_bundle(0));
        drive_cycle(1'b1, 1'b1, rand_bundle(0));
        drive_cycle(1'b0, 1'b0, quiet);
        report_test("bypass", e0);
    endtask

    task automatic test_full();
        int e0;
        e0 = n_errors;
        repeat (BUF_DEPTH) drive_cycle(1'b1, 1'b0, rand_bundle(0));
        drive_cycle(1'b1, 1'b0, rand_bundle(0));  // dropped
        repeat (BUF_DEPTH) drive_cycle(1'b0, 1'b1, quiet);
        drive_cycle(1'b0, 1'b0, quiet);
        report_test("full", e0);
    endtask

    task automatic test_ibar();
        int e0;
        e0 = n_errors;
        drive_cycle(1'b1, 1'b0, rand_bundle(1));
        drive_cycle(1'b0, 1'b0, quiet);
        drive_cycle(1'b1, 1'b0, rand_bundle(2));
        drive_cycle(1'b1, 1'b0, rand_bundle(0));
        drive_cycle(1'b0, 1'b0, quiet);
        repeat (3) drive_cycle(1'b0, 1'b1, quiet);
        drive_cycle(1'b1, 1'b1, rand_bundle(2));  // bypassed ibar
        drive_cycle(1'b1, 1'b1, rand_bundle(1));
        drive_cycle(1'b0, 1'b0, quiet);
        report_test("ibar", e0);
    endtask

    task automatic test_random();
        int   e0;
        int   slot;
        logic valid;
        logic ready;
        e0 = n_errors;
        repeat (300) begin
            valid = ($urandom_range(0, 1) == 1) && (model_q.size() < BUF_DEPTH);
            ready = ($urandom_range(0, 2) != 0);
            slot  = $urandom_range(0, 7);
            drive_cycle(valid, ready, rand_bundle(slot));
        end
        repeat (BUF_DEPTH + 1) drive_cycle(1'b0, 1'b1, quiet);
        report_test("random", e0);
    endtask

    initial begin
        void'($urandom(53535));
        rst_n_i           = 1'b0;
        fetch_valid_i     = 1'b0;
        decode_ready_i    = 1'b0;
        fetch_bundle_i    = '0;
        quiet             = '0;
        exp_refetch_valid = 1'b0;
        exp_refetch_pc    = '0;
        n_checks          = 0;
        n_errors          = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        test_reset();
        test_order();
        test_bypass();
        test_full();
        test_ibar();
        test_random();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/fetch_queue_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue_assert (
    input wire                           clk,
    input wire                           rst_n_i,
    input wire                           fetch_valid_i,
    input wire fetch_pkg::fetch_bundle_t fetch_bundle_i,
    input wire                           decode_ready_i,
    input wire fetch_pkg::queue_entry_t  decode_entry_i,
    input wire                           fetch_buf_empty_i,
    input wire                           fetch_buf_full_i,
    input wire                           ibar_refetch_valid_i
);
    import isa_pkg::*;

    logic bypass;
    logic ibar_in;     // incoming bundle holds an ibar
    logic ibar_taken;

    assign bypass     = fetch_buf_empty_i && fetch_valid_i && decode_ready_i;
    assign ibar_in    = (fetch_bundle_i.inst0[31:IBAR_LSB] == IBAR_OPCODE)
                     || (fetch_bundle_i.inst1[31:IBAR_LSB] == IBAR_OPCODE);
    assign ibar_taken = fetch_valid_i && !fetch_buf_full_i && ibar_in;  // full drops it

    empty_full_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(fetch_buf_empty_i && fetch_buf_full_i))
        else $error("fifo reports empty and full at once");

    // a second pulse cycle needs a fresh ibar bundle
    refetch_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ibar_refetch_valid_i && $past(ibar_refetch_valid_i))
            |-> $past(ibar_taken))
        else $error("refetch pulse held without a new ibar bundle");

    idle_shows_nop: assert property (@(posedge clk) disable iff (!rst_n_i)
        (fetch_buf_empty_i && !bypass)
            |-> (decode_entry_i.bundle.inst0 == INST_NOP
                 && decode_entry_i.bundle.inst1 == INST_NOP))
        else $error("empty queue does not show the nop pair");

endmodule

`default_nettype wire

// ==== src/fetch_queue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue_top #(
    parameter int BUF_DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      fetch_valid_i,
    input  wire fetch_pkg::fetch_bundle_t fetch_bundle_i,
    input  wire                      decode_ready_i,
    output fetch_pkg::queue_entry_t  decode_entry_o,
    output logic [31:0]              pc_add_o,
    output logic                     fetch_buf_empty_o,
    output logic                     fetch_buf_full_o,
    output logic                     ibar_refetch_valid_o,
    output logic [31:0]              ibar_refetch_pc_o
);

    logic [1:0] ibar_flag;
    logic       accept;  // pushed or bypassed

    pre_decoder pre_decoder_i (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .accept_i             (accept),
        .fetch_bundle_i       (fetch_bundle_i),
        .ibar_flag_o          (ibar_flag),
        .ibar_refetch_valid_o (ibar_refetch_valid_o),
        .ibar_refetch_pc_o    (ibar_refetch_pc_o)
    );

    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) fetch_buffer_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .fetch_valid_i     (fetch_valid_i),
        .fetch_bundle_i    (fetch_bundle_i),
        .ibar_flag_i       (ibar_flag),
        .decode_ready_i    (decode_ready_i),
        .accept_o          (accept),
        .decode_entry_o    (decode_entry_o),
        .pc_add_o          (pc_add_o),
        .fetch_buf_empty_o (fetch_buf_empty_o),
        .fetch_buf_full_o  (fetch_buf_full_o)
    );

endmodule

`default_nettype wire

// ==== src/fetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      fetch_valid_i,
    input  wire fetch_pkg::fetch_bundle_t fetch_bundle_i,
    input  wire [1:0]                ibar_flag_i,
    input  wire                      decode_ready_i,
    output logic                     accept_o,
    output fetch_pkg::queue_entry_t  decode_entry_o,
    output logic [31:0]              pc_add_o,
    output logic                     fetch_buf_empty_o,
    output logic                     fetch_buf_full_o
);
    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int ENTRY_W = $bits(queue_entry_t);

    queue_entry_t in_entry;
    queue_entry_t head_entry;
    queue_entry_t default_entry;
    logic         bypass;
    logic         push;
    logic         pop;

    assign in_entry.bundle    = fetch_bundle_i;
    assign in_entry.ibar_flag = ibar_flag_i;

    // skip the storage when the queue is empty and decode takes the bundle now
    assign bypass = fetch_buf_empty_o && fetch_valid_i && decode_ready_i;
    assign push   = fetch_valid_i && !fetch_buf_full_o && !bypass;  // dropped when full
    assign pop    = decode_ready_i && !fetch_buf_empty_o;

    assign accept_o = push || bypass;

    sync_fifo #(
        .DATA_WIDTH (ENTRY_W),
        .DEPTH      (BUF_DEPTH)
    ) sync_fifo_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (push),
        .pop_i   (pop),
        .din_i   (in_entry),
        .dout_o  (head_entry),
        .full_o  (fetch_buf_full_o),
        .empty_o (fetch_buf_empty_o)
    );

    // nop pair at the reset pc while nothing is there
    always_comb begin
        default_entry                = '0;
        default_entry.bundle.inst0   = INST_NOP;
        default_entry.bundle.inst1   = INST_NOP;
        default_entry.bundle.pc      = PC_RESET;
        default_entry.bundle.pc_next = PC_RESET + 32'd8;
        default_entry.bundle.badv    = PC_RESET;
    end

    always_comb begin
        if (bypass) begin
            decode_entry_o = in_entry;
        end else if (!fetch_buf_empty_o) begin
            decode_entry_o = head_entry;
        end else begin
            decode_entry_o = default_entry;
        end
    end

    assign pc_add_o = decode_entry_o.bundle.pc + 32'd4;  // pc of inst1

endmodule

`default_nettype wire

// ==== src/pre_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module pre_decoder (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      accept_i,
    input  wire fetch_pkg::fetch_bundle_t fetch_bundle_i,
    output logic [1:0]               ibar_flag_o,
    output logic                     ibar_refetch_valid_o,
    output logic [31:0]              ibar_refetch_pc_o
);
    import isa_pkg::*;

    inst_class_e slot_class [2];
    logic        has_ibar;
    logic [31:0] refetch_pc;

    function automatic inst_class_e classify(input logic [31:0] inst);
        if (inst[31:IBAR_LSB] == IBAR_OPCODE) begin
            return INST_CLASS_IBAR;
        end
        return INST_CLASS_NORMAL;
    endfunction

    assign slot_class[0] = classify(fetch_bundle_i.inst0);
    assign slot_class[1] = classify(fetch_bundle_i.inst1);

    assign ibar_flag_o[0] = (slot_class[0] == INST_CLASS_IBAR);
    assign ibar_flag_o[1] = (slot_class[1] == INST_CLASS_IBAR);
    assign has_ibar       = |ibar_flag_o;

    // restart right behind the first ibar of the bundle
    assign refetch_pc = fetch_bundle_i.pc + (ibar_flag_o[0] ? 32'd4 : 32'd8);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ibar_refetch_valid_o <= 1'b0;
        end else begin
            ibar_refetch_valid_o <= accept_i && has_ibar;  // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i && has_ibar) begin
            ibar_refetch_pc_o <= refetch_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 8
) (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   push_i,
    input  wire                   pop_i,
    input  wire  [DATA_WIDTH-1:0] din_i,
    output logic [DATA_WIDTH-1:0] dout_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [CNT_W-1:0]      count;

    // wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or push+pop
            endcase
        end
    end

    assign dout_o  = mem[rd_ptr];  // head without read latency
    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

endmodule

`default_nettype wire

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // one IF1 bundle with inst0 at the lower address
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;         // pc of inst0
        logic [31:0] pc_next;
        logic [31:0] badv;       // icache bad address
        logic [31:0] cookie;
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic        cacop_ready;
        logic        cacop_complete;
    } fetch_bundle_t;

    // what the queue stores and hands to decode
    typedef struct packed {
        fetch_bundle_t bundle;
        logic [1:0]    ibar_flag;  // bit k set for ibar in slot k
    } queue_entry_t;

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // andi r0, r0, 0
    localparam logic [31:0] INST_NOP = 32'h0340_0000;

    localparam logic [31:0] PC_RESET = 32'h1c00_0000;

    // ibar hint sits in bits 14:0 below the fixed opcode
    localparam int          IBAR_LSB    = 15;
    localparam logic [16:0] IBAR_OPCODE = 17'h070e5;

    // only ibar matters to the fetch queue for now
    typedef enum logic {
        INST_CLASS_NORMAL = 1'b0,
        INST_CLASS_IBAR   = 1'b1
    } inst_class_e;

endpackage

`default_nettype wire
